// File: bench/pixel_locator_asserts.sv
`timescale 1ns/10ps

module pixel_locator_asserts import detect_pkg::*; #(
    parameter int FIFO_DEPTH = FIFO_DEPTH_DEFAULT
) (
    input logic                            clk_pixel,
    input logic                            recent_reset,
    input logic                            out_valid,
    input logic                            out_credit,
    input logic                            in_credit,
    input credit_count_t                   out_credit_count,
    input logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count
);

    // number of failed assertions so far
    int failures = 0;
    // credits granted by downstream and not yet spent on a beat
    int unspent_credits;

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            unspent_credits <= 0;
        end else begin
            unspent_credits <= unspent_credits + (out_credit ? 1 : 0) - (out_valid ? 1 : 0);
        end
    end

    // a beat is only sent against a credit the downstream has granted
    beat_needs_credit: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        out_valid |-> (unspent_credits > 0))
        else begin
            failures++;
            $error("out_valid high with no output credit granted");
        end

    // the mixer never holds more credits than were granted
    credit_count_backed: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        int'(out_credit_count) <= unspent_credits)
        else begin
            failures++;
            $error("output credit count above the credits granted");
        end

    // occupancy bounded by the buffer depth
    fifo_bounded: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        fifo_count <= FIFO_DEPTH)
        else begin
            failures++;
            $error("fifo count above depth");
        end

    // both handshake outputs quiet right after reset
    quiet_after_reset: assert property (@(posedge clk_pixel)
        recent_reset |=> (!in_credit && !out_valid))
        else begin
            failures++;
            $error("in_credit or out_valid high after reset");
        end

endmodule

bind overlay_mixer pixel_locator_asserts #(
    .FIFO_DEPTH(FIFO_DEPTH)
) i_pixel_locator_asserts (
    .clk_pixel       (clk_pixel),
    .recent_reset    (recent_reset),
    .out_valid       (out_valid),
    .out_credit      (out_credit),
    .in_credit       (in_credit),
    .out_credit_count(out_credit_count),
    .fifo_count      (fifo_count)
);

// File: bench/tb_pixel_locator.sv
`timescale 1ns/10ps

module tb_pixel_locator
    import video_pkg::*, detect_pkg::*;
();

    // small test frame, well inside the default geometry
    localparam int FRAME_W = 16;
    localparam int FRAME_H = 12;
    localparam channel_t LOWER_TH = 8'd100;
    localparam channel_t UPPER_TH = 8'd200;
    localparam int WAIT_LIMIT = 4000;
    // divider needs at most 26 cycles after frame end
    localparam int DIV_SETTLE = 30;
    localparam int POLICY_NONE = 0;
    localparam int POLICY_FULL = 1;
    localparam int POLICY_SPARSE = 2;

    logic        clk_pixel;
    logic        recent_reset;
    logic        in_valid;
    pixel_word_u in_pixel;
    x_coord_t    in_x;
    y_coord_t    in_y;
    logic        in_frame_end;
    logic        in_credit;
    channel_t    lower_threshold;
    channel_t    upper_threshold;
    logic        out_valid;
    pixel_word_u out_pixel;
    x_coord_t    out_x;
    y_coord_t    out_y;
    logic        out_credit;
    x_coord_t    com_x;
    y_coord_t    com_y;
    logic        com_valid;

    // upstream credit state and downstream grant policy
    int          up_credits;
    int          credit_policy;
    logic [63:0] sparse_pattern;
    int          pat_idx;
    int          value_errors;
    int          other_errors;
    int          in_credit_pulses;
    int          out_beats;
    // expected stream, captured stream and reference capture
    pixel_word_u exp_pix_q[$];
    x_coord_t    exp_x_q[$];
    y_coord_t    exp_y_q[$];
    pixel_word_u got_q[$];
    pixel_word_u ref_q[$];
    pixel_word_u frame_pix[FRAME_W*FRAME_H];
    // reference model of the held center of mass
    logic        model_com_valid;
    x_coord_t    model_com_x;
    y_coord_t    model_com_y;
    longint      sum_x;
    longint      sum_y;
    int          spot_n;

    pixel_locator i_pixel_locator (.*);

    initial begin
        clk_pixel = 1'b0;
        forever #5 clk_pixel = ~clk_pixel;
    end

    // out_credit grants, changed 1 ns after each rising edge
    initial begin
        out_credit = 1'b0;
        pat_idx = 0;
        forever begin
            @(posedge clk_pixel);
            #1;
            if (credit_policy == POLICY_FULL) begin
                out_credit = 1'b1;
            end else if (credit_policy == POLICY_SPARSE) begin
                out_credit = sparse_pattern[pat_idx];
                pat_idx = (pat_idx + 1) % 64;
            end else begin
                out_credit = 1'b0;
            end
        end
    end

    task automatic check_pixel(input string name, input pixel_word_u got, input pixel_word_u exp);
        if (got !== exp) begin
            value_errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_coord(input string name, input x_coord_t got, input x_coord_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk_pixel) begin
        if (in_credit) begin
            in_credit_pulses++;
            up_credits++;
        end
        if (out_valid) begin
            out_beats++;
            got_q.push_back(out_pixel);
            if (exp_pix_q.size() == 0) begin
                other_errors++;
                $display("error at %0t: output beat with no pixel expected", $time);
            end else begin
                check_pixel("out_pixel", out_pixel, exp_pix_q.pop_front());
                check_coord("out_x", out_x, exp_x_q.pop_front());
                check_coord("out_y", x_coord_t'(out_y), x_coord_t'(exp_y_q.pop_front()));
            end
        end
    end

    task automatic print_counts();
        $display("value errors %0d, other errors %0d, assertion failures %0d, beats %0d",
            value_errors, other_errors,
            i_pixel_locator.i_overlay_mixer.i_pixel_locator_asserts.failures, out_beats);
    endtask

    task automatic abort_run(input string why);
        other_errors++;
        $display("timeout at %0t: %s", $time, why);
        print_counts();
        $display("TB FAILED");
        $finish;
    endtask

    function automatic channel_t outside_level();
        // either below or above the threshold window
        if ($urandom % 2) return channel_t'($urandom % 100);
        return channel_t'(201 + $urandom % 55);
    endfunction

    function automatic logic in_window(input channel_t level);
        return (level >= LOWER_TH) && (level <= UPPER_TH);
    endfunction

    // drives one pixel once a credit is held and records what must come out
    task automatic send_pixel(input pixel_word_u pix, input int x, input int y, input logic fe);
        int          waited;
        pixel_word_u exp;
        waited = 0;
        while (up_credits == 0) begin
            @(posedge clk_pixel);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) abort_run("no input credit came back");
        end
        up_credits--;
        in_valid = 1'b1;
        in_pixel = pix;
        in_x = x_coord_t'(x);
        in_y = y_coord_t'(y);
        in_frame_end = fe;
        // crosshair first, then id mark, then camera pixel
        exp = pix;
        if (model_com_valid && (x == model_com_x || y == model_com_y)) begin
            exp = COLOR_CROSSHAIR;
        end else if (in_window(pix.rgb.blue)) begin
            exp = COLOR_ID_MARK;
        end
        exp_pix_q.push_back(exp);
        exp_x_q.push_back(x_coord_t'(x));
        exp_y_q.push_back(y_coord_t'(y));
        if (in_window(pix.rgb.red)) begin
            sum_x += x;
            sum_y += y;
            spot_n++;
        end
        // truncated mean over the frame, held across empty frames
        if (fe) begin
            if (spot_n != 0) begin
                model_com_x = x_coord_t'(sum_x / spot_n);
                model_com_y = y_coord_t'(sum_y / spot_n);
                model_com_valid = 1'b1;
            end
            sum_x = 0;
            sum_y = 0;
            spot_n = 0;
        end
        @(posedge clk_pixel);
        #1;
        in_valid = 1'b0;
        in_frame_end = 1'b0;
    endtask

    // background outside the window, id marks on window edges, optional red block
    task automatic build_frame(input logic spot);
        pixel_word_u p;
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < FRAME_W; x++) begin
                p.rgb.red = outside_level();
                p.rgb.green = channel_t'($urandom);
                p.rgb.blue = outside_level();
                if ((x + y) % 5 == 0) p.rgb.blue = ((x + y) % 10 == 0) ? LOWER_TH : UPPER_TH;
                if (spot && x >= 5 && x <= 8 && y >= 3 && y <= 5) begin
                    p.rgb.red = (x % 2) ? UPPER_TH : LOWER_TH;
                end
                frame_pix[y*FRAME_W+x] = p;
            end
        end
    endtask

    task automatic drive_frame();
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < FRAME_W; x++) begin
                send_pixel(frame_pix[y*FRAME_W+x], x, y, (x == FRAME_W-1) && (y == FRAME_H-1));
            end
        end
    endtask

    // all expected beats out and every input credit returned
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_pix_q.size() != 0 || up_credits != FIFO_DEPTH_DEFAULT) begin
            @(posedge clk_pixel);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) abort_run("output stream did not drain");
        end
    endtask

    task automatic settle_divider();
        repeat (DIV_SETTLE) @(posedge clk_pixel);
        #1;
    endtask

    task automatic test_idle_without_credit();
        pixel_word_u p;
        for (int i = 0; i < FIFO_DEPTH_DEFAULT; i++) begin
            p.rgb.red = outside_level();
            p.rgb.green = channel_t'($urandom);
            p.rgb.blue = outside_level();
            send_pixel(p, i, 0, 1'b0);
        end
        // nothing may leave without output credit
        for (int i = 0; i < 20; i++) begin
            check_flag("out_valid", out_valid, 1'b0);
            check_flag("in_credit", in_credit, 1'b0);
            check_flag("com_valid", com_valid, 1'b0);
            @(posedge clk_pixel);
            #1;
        end
        credit_policy = POLICY_FULL;
        wait_drain();
    endtask

    task automatic test_plain_frame();
        build_frame(1'b0);
        drive_frame();
        wait_drain();
        settle_divider();
        check_flag("com_valid", com_valid, 1'b0);
    endtask

    task automatic test_spot_frame();
        int waited;
        build_frame(1'b1);
        drive_frame();
        waited = 0;
        while (!com_valid) begin
            @(posedge clk_pixel);
            #1;
            waited++;
            if (waited > DIV_SETTLE + 10) abort_run("com_valid never rose after the spot frame");
        end
        check_coord("com_x", com_x, model_com_x);
        check_coord("com_y", x_coord_t'(com_y), x_coord_t'(model_com_y));
        wait_drain();
        settle_divider();
    endtask

    // same block again keeps the centroid, crosshair now drawn
    task automatic test_crosshair_frame();
        got_q.delete();
        build_frame(1'b1);
        drive_frame();
        wait_drain();
        settle_divider();
        ref_q = got_q;
        check_coord("com_x", com_x, model_com_x);
        check_coord("com_y", x_coord_t'(com_y), x_coord_t'(model_com_y));
    endtask

    task automatic test_backpressure();
        int pulses_before;
        int beats_before;
        got_q.delete();
        pulses_before = in_credit_pulses;
        beats_before = out_beats;
        credit_policy = POLICY_SPARSE;
        drive_frame();
        wait_drain();
        settle_divider();
        credit_policy = POLICY_FULL;
        if (got_q.size() != ref_q.size()) begin
            other_errors++;
            $display("error: %0d beats under back-pressure, %0d with full credit",
                got_q.size(), ref_q.size());
        end else begin
            foreach (got_q[i]) check_pixel("out_pixel", got_q[i], ref_q[i]);
        end
        if (in_credit_pulses - pulses_before != out_beats - beats_before) begin
            other_errors++;
            $display("error: %0d in_credit pulses for %0d output beats",
                in_credit_pulses - pulses_before, out_beats - beats_before);
        end
    endtask

    task automatic test_empty_after_spot();
        build_frame(1'b0);
        drive_frame();
        wait_drain();
        settle_divider();
        check_flag("com_valid", com_valid, 1'b1);
        check_coord("com_x", com_x, model_com_x);
        check_coord("com_y", x_coord_t'(com_y), x_coord_t'(model_com_y));
    endtask

    initial begin
        void'($urandom(2766));
        // roughly one grant in four
        for (int i = 0; i < 64; i++) sparse_pattern[i] = ($urandom % 4) == 0;
        recent_reset = 1'b1;
        in_valid = 1'b0;
        in_pixel = '0;
        in_x = '0;
        in_y = '0;
        in_frame_end = 1'b0;
        lower_threshold = LOWER_TH;
        upper_threshold = UPPER_TH;
        up_credits = FIFO_DEPTH_DEFAULT;
        credit_policy = POLICY_NONE;
        value_errors = 0;
        other_errors = 0;
        in_credit_pulses = 0;
        out_beats = 0;
        model_com_valid = 1'b0;
        model_com_x = '0;
        model_com_y = '0;
        sum_x = 0;
        sum_y = 0;
        spot_n = 0;
        repeat (8) @(posedge clk_pixel);
        #1;
        recent_reset = 1'b0;
        test_idle_without_credit();
        test_plain_frame();
        test_spot_frame();
        test_crosshair_frame();
        test_backpressure();
        test_empty_after_spot();
        print_counts();
        if (value_errors + other_errors +
            i_pixel_locator.i_overlay_mixer.i_pixel_locator_asserts.failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: pixel_locator.f
src/video_pkg.sv
src/detect_pkg.sv
src/mask_detector.sv
src/centroid_tracker.sv
src/overlay_mixer.sv
src/pixel_locator.sv
bench/pixel_locator_asserts.sv
bench/tb_pixel_locator.sv

// File: src/centroid_tracker.sv
`timescale 1ns/10ps

module centroid_tracker import video_pkg::*, detect_pkg::*; #(
    parameter int FRAME_WIDTH = FRAME_WIDTH_DEFAULT,
    parameter int FRAME_HEIGHT = FRAME_HEIGHT_DEFAULT
) (
    input  logic       clk_pixel,
    input  logic       recent_reset,
    input  logic       det_valid,
    input  x_coord_t   det_x,
    input  y_coord_t   det_y,
    input  logic       det_frame_end,
    input  mask_bits_t det_mask,
    output x_coord_t   com_x,
    output y_coord_t   com_y,
    output logic       com_valid
);

    // the mean never exceeds the largest coordinate
    // so only this many quotient bits are computed
    localparam int X_BITS = $clog2(FRAME_WIDTH);
    localparam int Y_BITS = $clog2(FRAME_HEIGHT);

    sum_x_t       sum_x;
    sum_y_t       sum_y;
    pixel_count_t spot_count;
    sum_x_t       frame_sum_x;
    sum_y_t       frame_sum_y;
    pixel_count_t frame_count;
    logic         spot_hit;
    logic         frame_done;
    logic         div_start;
    // divider state, one datapath shared by the x and y phases
    pixel_count_t div_count;
    sum_y_t       held_sum_y;
    sum_x_t       div_rem;
    sum_x_t       div_shift;
    logic [3:0]   bit_idx;
    x_coord_t     quot;
    x_coord_t     quot_next;
    x_coord_t     res_x;
    logic         div_busy;
    logic         div_phase_y;
    logic         fits;
    logic         last_step;
    sum_x_t       rem_next;

    assign spot_hit = det_valid && det_mask[MASK_SPOT_BIT];
    assign frame_done = det_valid && det_frame_end;

    // tally including the pixel now on the bus
    assign frame_sum_x = sum_x + (spot_hit ? sum_x_t'(det_x) : sum_x_t'(0));
    assign frame_sum_y = sum_y + (spot_hit ? sum_y_t'(det_y) : sum_y_t'(0));
    assign frame_count = spot_count + pixel_count_t'(spot_hit);

    // empty frames never start the divider
    assign div_start = frame_done && (frame_count != '0);

    always_ff @(posedge clk_pixel) begin
        if (recent_reset || frame_done) begin
            sum_x <= '0;
            sum_y <= '0;
            spot_count <= '0;
        end else begin
            sum_x <= frame_sum_x;
            sum_y <= frame_sum_y;
            spot_count <= frame_count;
        end
    end

    // restoring step against the divisor shifted to the current bit
    assign fits = div_rem >= div_shift;
    assign rem_next = fits ? div_rem - div_shift : div_rem;
    assign quot_next = fits ? (quot | (x_coord_t'(1) << bit_idx)) : quot;
    // a zero remainder leaves only zero quotient bits, so stop early
    assign last_step = (bit_idx == '0) || (rem_next == '0);

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            div_busy <= 1'b0;
            div_phase_y <= 1'b0;
            com_valid <= 1'b0;
        end else if (div_start) begin
            div_busy <= 1'b1;
            div_phase_y <= 1'b0;
        end else if (div_busy && last_step) begin
            if (div_phase_y) begin
                div_busy <= 1'b0;
                com_valid <= 1'b1;
            end else begin
                div_phase_y <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (div_start) begin
            // x phase first, y sum waits in held_sum_y
            div_count <= frame_count;
            held_sum_y <= frame_sum_y;
            div_rem <= frame_sum_x;
            div_shift <= sum_x_t'(frame_count) << (X_BITS - 1);
            bit_idx <= 4'(X_BITS - 1);
            quot <= '0;
        end else if (div_busy) begin
            if (!last_step) begin
                div_rem <= rem_next;
                div_shift <= div_shift >> 1;
                bit_idx <= bit_idx - 1'b1;
                quot <= quot_next;
            end else if (!div_phase_y) begin
                // x done, load the y division
                res_x <= quot_next;
                div_rem <= held_sum_y;
                div_shift <= sum_x_t'(div_count) << (Y_BITS - 1);
                bit_idx <= 4'(Y_BITS - 1);
                quot <= '0;
            end else begin
                // both results update in the same cycle
                com_x <= res_x;
                com_y <= y_coord_t'(quot_next);
            end
        end
    end

endmodule

// File: src/detect_pkg.sv
package detect_pkg;

    // per-pixel threshold results
    // bit 0 is the id hit and bit 1 the spot hit
    typedef logic [1:0] mask_bits_t;
    localparam int MASK_ID_BIT = 0;
    localparam int MASK_SPOT_BIT = 1;

    // running coordinate sums over all spot pixels of a frame
    typedef logic [23:0] sum_x_t;
    typedef logic [23:0] sum_y_t;

    // number of spot pixels in a frame
    typedef logic [13:0] pixel_count_t;

    // output buffer depth
    // the upstream also starts out with this many credits
    localparam int FIFO_DEPTH_DEFAULT = 4;

    // output credits held by the mixer
    typedef logic [2:0] credit_count_t;

endpackage

// File: src/mask_detector.sv
`timescale 1ns/10ps

module mask_detector import video_pkg::*, detect_pkg::*; #(
    parameter int ID_CHANNEL = CHAN_BLUE,
    parameter int SPOT_CHANNEL = CHAN_RED
) (
    input  logic        clk_pixel,
    input  logic        recent_reset,
    input  logic        in_valid,
    input  pixel_word_u in_pixel,
    input  x_coord_t    in_x,
    input  y_coord_t    in_y,
    input  logic        in_frame_end,
    input  channel_t    lower_threshold,
    input  channel_t    upper_threshold,
    output logic        det_valid,
    output pixel_word_u det_pixel,
    output x_coord_t    det_x,
    output y_coord_t    det_y,
    output logic        det_frame_end,
    output mask_bits_t  det_mask
);

    channel_t id_level;
    channel_t spot_level;
    logic     id_hit;
    logic     spot_hit;

    // pick the two tested channels by number
    assign id_level = in_pixel.chan[ID_CHANNEL];
    assign spot_level = in_pixel.chan[SPOT_CHANNEL];

    // window test with both bounds inclusive
    assign id_hit = (id_level >= lower_threshold) && (id_level <= upper_threshold);
    assign spot_hit = (spot_level >= lower_threshold) && (spot_level <= upper_threshold);

    // one stage of valid
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            det_valid <= 1'b0;
        end else begin
            det_valid <= in_valid;
        end
    end

    // mask bits travel with their pixel and position
    // so tracker and mixer see them aligned
    always_ff @(posedge clk_pixel) begin
        if (in_valid) begin
            det_pixel <= in_pixel;
            det_x <= in_x;
            det_y <= in_y;
            det_frame_end <= in_frame_end;
            det_mask[MASK_ID_BIT] <= id_hit;
            det_mask[MASK_SPOT_BIT] <= spot_hit;
        end
    end

endmodule

// File: src/overlay_mixer.sv
`timescale 1ns/10ps

module overlay_mixer import video_pkg::*, detect_pkg::*; #(
    parameter int FIFO_DEPTH = FIFO_DEPTH_DEFAULT
) (
    input  logic        clk_pixel,
    input  logic        recent_reset,
    input  logic        det_valid,
    input  pixel_word_u det_pixel,
    input  x_coord_t    det_x,
    input  y_coord_t    det_y,
    input  mask_bits_t  det_mask,
    input  x_coord_t    com_x,
    input  y_coord_t    com_y,
    input  logic        com_valid,
    input  logic        out_credit,
    output logic        in_credit,
    output logic        out_valid,
    output pixel_word_u out_pixel,
    output x_coord_t    out_x,
    output y_coord_t    out_y
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    pixel_word_u      fifo_pixel [FIFO_DEPTH];
    x_coord_t         fifo_x [FIFO_DEPTH];
    y_coord_t         fifo_y [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fifo_count;
    credit_count_t    out_credit_count;
    pixel_word_u      mix_pixel;
    logic             on_crosshair;
    logic             push;
    logic             pop;

    // pointer wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // crosshair wins over the id mark
    assign on_crosshair = com_valid && ((det_x == com_x) || (det_y == com_y));

    always_comb begin
        mix_pixel = det_pixel;
        if (on_crosshair) begin
            mix_pixel = COLOR_CROSSHAIR;
        end else if (det_mask[MASK_ID_BIT]) begin
            mix_pixel = COLOR_ID_MARK;
        end
    end

    // every beat is consumed downstream since it was paid for with a credit
    assign push = det_valid;
    assign out_valid = (fifo_count != '0) && (out_credit_count != '0);
    assign pop = out_valid;
    assign out_pixel = fifo_pixel[rd_ptr];
    assign out_x = fifo_x[rd_ptr];
    assign out_y = fifo_y[rd_ptr];

    always_ff @(posedge clk_pixel) begin
        if (push) begin
            fifo_pixel[wr_ptr] <= mix_pixel;
            fifo_x[wr_ptr] <= det_x;
            fifo_y[wr_ptr] <= det_y;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fifo_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (push && !pop) begin
                fifo_count <= fifo_count + 1'b1;
            end else if (pop && !push) begin
                fifo_count <= fifo_count - 1'b1;
            end
        end
    end

    // output credits in from downstream, one returned upstream per pop
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            out_credit_count <= '0;
            in_credit <= 1'b0;
        end else begin
            in_credit <= pop;
            // Saturates so a downstream that overgrants cannot wrap the count
            if (out_credit && !pop && (out_credit_count != '1)) begin
                out_credit_count <= out_credit_count + 1'b1;
            end else if (pop && !out_credit) begin
                out_credit_count <= out_credit_count - 1'b1;
            end
        end
    end

endmodule

// File: src/pixel_locator.sv
`timescale 1ns/10ps

module pixel_locator import video_pkg::*, detect_pkg::*; #(
    parameter int FRAME_WIDTH = FRAME_WIDTH_DEFAULT,
    parameter int FRAME_HEIGHT = FRAME_HEIGHT_DEFAULT,
    parameter int FIFO_DEPTH = FIFO_DEPTH_DEFAULT
) (
    input  logic        clk_pixel,
    input  logic        recent_reset,
    // camera pixel stream
    input  logic        in_valid,
    input  pixel_word_u in_pixel,
    input  x_coord_t    in_x,
    input  y_coord_t    in_y,
    input  logic        in_frame_end,
    output logic        in_credit,
    // threshold window, held stable within a frame
    input  channel_t    lower_threshold,
    input  channel_t    upper_threshold,
    // overlaid pixel stream
    output logic        out_valid,
    output pixel_word_u out_pixel,
    output x_coord_t    out_x,
    output y_coord_t    out_y,
    input  logic        out_credit,
    // held center of mass
    output x_coord_t    com_x,
    output y_coord_t    com_y,
    output logic        com_valid
);

    // detector outputs shared by tracker and mixer
    logic        det_valid;
    pixel_word_u det_pixel;
    x_coord_t    det_x;
    y_coord_t    det_y;
    logic        det_frame_end;
    mask_bits_t  det_mask;

    // blue selects the id bit and red the spot bit
    mask_detector #(
        .ID_CHANNEL  (CHAN_BLUE),
        .SPOT_CHANNEL(CHAN_RED)
    ) i_mask_detector (
        .clk_pixel      (clk_pixel),
        .recent_reset   (recent_reset),
        .in_valid       (in_valid),
        .in_pixel       (in_pixel),
        .in_x           (in_x),
        .in_y           (in_y),
        .in_frame_end   (in_frame_end),
        .lower_threshold(lower_threshold),
        .upper_threshold(upper_threshold),
        .det_valid      (det_valid),
        .det_pixel      (det_pixel),
        .det_x          (det_x),
        .det_y          (det_y),
        .det_frame_end  (det_frame_end),
        .det_mask       (det_mask)
    );

    centroid_tracker #(
        .FRAME_WIDTH (FRAME_WIDTH),
        .FRAME_HEIGHT(FRAME_HEIGHT)
    ) i_centroid_tracker (
        .clk_pixel    (clk_pixel),
        .recent_reset (recent_reset),
        .det_valid    (det_valid),
        .det_x        (det_x),
        .det_y        (det_y),
        .det_frame_end(det_frame_end),
        .det_mask     (det_mask),
        .com_x        (com_x),
        .com_y        (com_y),
        .com_valid    (com_valid)
    );

    overlay_mixer #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_overlay_mixer (
        .clk_pixel   (clk_pixel),
        .recent_reset(recent_reset),
        .det_valid   (det_valid),
        .det_pixel   (det_pixel),
        .det_x       (det_x),
        .det_y       (det_y),
        .det_mask    (det_mask),
        .com_x       (com_x),
        .com_y       (com_y),
        .com_valid   (com_valid),
        .out_credit  (out_credit),
        .in_credit   (in_credit),
        .out_valid   (out_valid),
        .out_pixel   (out_pixel),
        .out_x       (out_x),
        .out_y       (out_y)
    );

endmodule

// File: src/video_pkg.sv
package video_pkg;

    // frame size used in simulation
    // a real sensor overrides it through the top level parameters
    localparam int FRAME_WIDTH_DEFAULT = 64;
    localparam int FRAME_HEIGHT_DEFAULT = 48;

    // pixel position sized for a 1280x720 sensor
    typedef logic [10:0] x_coord_t;
    typedef logic [9:0] y_coord_t;

    // one 8-bit color channel
    typedef logic [7:0] channel_t;

    // one camera pixel word with red in the top byte
    typedef union packed {
        // named view for painting and checking colors
        struct packed {
            channel_t red;
            channel_t green;
            channel_t blue;
        } rgb;
        // indexed view where chan[0] is blue and chan[2] is red
        channel_t [2:0] chan;
    } pixel_word_u;

    // channel numbers in the indexed view
    localparam int CHAN_BLUE = 0;
    localparam int CHAN_RED = 2;

    // overlay colors in red, green, blue byte order
    localparam logic [23:0] COLOR_CROSSHAIR = 24'hFF_FF_FF;
    localparam logic [23:0] COLOR_ID_MARK = 24'hFF_00_FF;

endpackage
